// File: logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // processor word and DRAM line
  typedef logic [31:0] word_t;

  // byte k of a line sits at bits 8k+7:8k
  typedef logic [127:0] line_t;

  // line geometry
  localparam int LINE_BYTES = 16;
  localparam int WORDS_PER_LINE = 4;
  localparam int OFFSET_BITS = 4;

  // controller FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_EVICT,
    ST_FILL,
    ST_DONE
  } cache_state_e;

endpackage

`default_nettype wire

// File: logic/mem_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

// line-wide DRAM request bus
interface mem_bus_if #(
  parameter int LINE_ADDR_BITS = 12
);
  import cache_pkg::*;

  logic wren;
  logic rden;
  logic [LINE_ADDR_BITS-1:0] line_addr;
  line_t wdata;
  line_t rdata;
  logic mem_ready;

  // request levels held until mem_ready
  modport ctrl (
    output wren,
    output rden,
    output line_addr,
    output wdata,
    input rdata,
    input mem_ready
  );

  modport memory (
    input wren,
    input rden,
    input line_addr,
    input wdata,
    output rdata,
    output mem_ready
  );

endinterface

`default_nettype wire

// File: logic/line_store_if.sv
`timescale 1ns/1ns
`default_nettype none

// lookup and update path between controller and tag/data array
interface line_store_if #(
  parameter int ADDR_BITS = 16,
  parameter int INDEX_BITS = 6
);
  import cache_pkg::*;

  localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

  // lookup, result one cycle after rd_index
  logic [INDEX_BITS-1:0] rd_index;
  logic [TAG_BITS-1:0] hit_tag;
  logic hit_valid;
  logic hit_dirty;
  line_t hit_line;

  // update, writes every field and sets valid
  logic upd_en;
  logic [INDEX_BITS-1:0] upd_index;
  logic [TAG_BITS-1:0] upd_tag;
  logic upd_dirty;
  line_t upd_line;

  modport ctrl (
    output rd_index,
    input hit_tag,
    input hit_valid,
    input hit_dirty,
    input hit_line,
    output upd_en,
    output upd_index,
    output upd_tag,
    output upd_dirty,
    output upd_line
  );

  modport array (
    input rd_index,
    output hit_tag,
    output hit_valid,
    output hit_dirty,
    output hit_line,
    input upd_en,
    input upd_index,
    input upd_tag,
    input upd_dirty,
    input upd_line
  );

endinterface

`default_nettype wire

// File: logic/dram_model.sv
`timescale 1ns/1ns
`default_nettype none

module dram_model #(
  parameter int ADDR_BITS = 16,
  parameter int DRAM_LATENCY = 4
) (
  input logic clk,
  mem_bus_if.memory mem
);
  import cache_pkg::*;

  localparam int MEM_BYTES = 2 ** ADDR_BITS;
  localparam int CNT_BITS = $clog2(DRAM_LATENCY + 1);

  logic [7:0] mem_q [MEM_BYTES];
  logic [CNT_BITS-1:0] count_q;
  logic ready_q;
  line_t rdata_q;
  logic [ADDR_BITS-1:0] base_addr;
  logic req;
  logic latency_up;

  assign req = mem.wren || mem.rden;
  assign latency_up = count_q == CNT_BITS'(DRAM_LATENCY);

  // line address to byte base
  assign base_addr = {mem.line_addr, {OFFSET_BITS{1'b0}}};

  // byte k starts as the low 8 bits of k
  initial begin
    for (int k = 0; k < MEM_BYTES; k++) begin
      mem_q[k] = 8'(k);
    end
    count_q = '0;
    ready_q = 1'b0;
  end

  // latency counter, one-cycle ready pulse
  always @(posedge clk) begin
    if (latency_up) begin
      count_q <= '0;
      ready_q <= 1'b1;
    end else if (req && !ready_q) begin
      count_q <= count_q + 1'b1;
      ready_q <= 1'b0;
    end else begin
      count_q <= '0;
      ready_q <= 1'b0;
    end
  end

  // whole line moves on the ready edge
  always @(posedge clk) begin
    if (latency_up) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (mem.wren) begin
          mem_q[base_addr + ADDR_BITS'(b)] <= mem.wdata[8*b +: 8];
        end else begin
          rdata_q[8*b +: 8] <= mem_q[base_addr + ADDR_BITS'(b)];
        end
      end
    end
  end

  assign mem.rdata = rdata_q;
  assign mem.mem_ready = ready_q;

endmodule

`default_nettype wire

// File: logic/cache_array.sv
`timescale 1ns/1ns
`default_nettype none

module cache_array #(
  parameter int ADDR_BITS = 16,
  parameter int INDEX_BITS = 6
) (
  input logic clk,
  input logic rst,
  line_store_if.array ls
);
  import cache_pkg::*;

  localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
  localparam int LINES = 2 ** INDEX_BITS;

  logic [LINES-1:0] valid_q;
  logic [LINES-1:0] dirty_q;
  logic [TAG_BITS-1:0] tag_q [LINES];
  line_t line_q [LINES];

  logic hit_valid_q;
  logic hit_dirty_q;
  logic [TAG_BITS-1:0] hit_tag_q;
  line_t hit_line_q;

  // status bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (ls.upd_en) begin
      valid_q[ls.upd_index] <= 1'b1;
      dirty_q[ls.upd_index] <= ls.upd_dirty;
    end
  end

  always_ff @(posedge clk) begin
    if (ls.upd_en) begin
      tag_q[ls.upd_index] <= ls.upd_tag;
      line_q[ls.upd_index] <= ls.upd_line;
    end
  end

  // registered lookup
  always_ff @(posedge clk) begin
    if (rst) begin
      hit_valid_q <= 1'b0;
      hit_dirty_q <= 1'b0;
    end else begin
      hit_valid_q <= valid_q[ls.rd_index];
      hit_dirty_q <= dirty_q[ls.rd_index];
    end
  end

  always_ff @(posedge clk) begin
    hit_tag_q <= tag_q[ls.rd_index];
    hit_line_q <= line_q[ls.rd_index];
  end

  assign ls.hit_valid = hit_valid_q;
  assign ls.hit_dirty = hit_dirty_q;
  assign ls.hit_tag = hit_tag_q;
  assign ls.hit_line = hit_line_q;

endmodule

`default_nettype wire

// File: logic/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl #(
  parameter int ADDR_BITS = 16,
  parameter int INDEX_BITS = 6
) (
  input logic clk,
  input logic rst,
  input logic req_rd,
  input logic req_wr,
  input logic [ADDR_BITS-1:0] req_addr,
  input cache_pkg::word_t req_wdata,
  output cache_pkg::word_t resp_rdata,
  output logic resp_done,
  output logic resp_hit,
  output logic busy,
  line_store_if.ctrl ls,
  mem_bus_if.ctrl mem
);
  import cache_pkg::*;

  localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
  localparam int WSEL_BITS = $clog2(WORDS_PER_LINE);
  localparam int WORD_BITS = $bits(word_t);

  cache_state_e state_q;
  logic hit_q;
  logic accept;
  logic tag_match;

  // latched request
  logic wr_q;
  logic [TAG_BITS-1:0] tag_q;
  logic [INDEX_BITS-1:0] idx_q;
  logic [WSEL_BITS-1:0] wsel_q;
  word_t wdata_q;
  word_t rdata_q;

  line_t hit_merged;
  line_t fill_merged;

  function automatic line_t merge_word(line_t line, logic [WSEL_BITS-1:0] sel, word_t w);
    line_t r;
    r = line;
    r[sel*WORD_BITS +: WORD_BITS] = w;
    return r;
  endfunction

  function automatic word_t pick_word(line_t line, logic [WSEL_BITS-1:0] sel);
    return line[sel*WORD_BITS +: WORD_BITS];
  endfunction

  assign accept = (state_q == ST_IDLE) && (req_rd || req_wr);
  assign tag_match = ls.hit_valid && (ls.hit_tag == tag_q);

  assign hit_merged = merge_word(ls.hit_line, wsel_q, wdata_q);
  assign fill_merged = wr_q ? merge_word(mem.rdata, wsel_q, wdata_q) : mem.rdata;

  // lookup goes out with the request itself
  assign ls.rd_index = (state_q == ST_IDLE) ? req_addr[OFFSET_BITS +: INDEX_BITS] : idx_q;

  assign ls.upd_index = idx_q;
  assign ls.upd_tag = tag_q;

  always_comb begin
    ls.upd_en = 1'b0;
    ls.upd_dirty = 1'b0;
    ls.upd_line = hit_merged;
    case (state_q)
      ST_LOOKUP: begin
        if (tag_match && wr_q) begin
          ls.upd_en = 1'b1;
          ls.upd_dirty = 1'b1;
        end
      end
      ST_FILL: begin
        if (mem.mem_ready) begin
          ls.upd_en = 1'b1;
          ls.upd_dirty = wr_q;
          ls.upd_line = fill_merged;
        end
      end
      default: begin
      end
    endcase
  end

  // array output holds the victim while the index stays fixed
  assign mem.wren = state_q == ST_EVICT;
  assign mem.rden = state_q == ST_FILL;
  assign mem.line_addr = (state_q == ST_EVICT) ? {ls.hit_tag, idx_q} : {tag_q, idx_q};
  assign mem.wdata = ls.hit_line;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      hit_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          hit_q <= tag_match;
          if (tag_match) begin
            state_q <= ST_DONE;
          end else if (ls.hit_valid && ls.hit_dirty) begin
            state_q <= ST_EVICT;
          end else begin
            state_q <= ST_FILL;
          end
        end
        ST_EVICT: begin
          if (mem.mem_ready) begin
            state_q <= ST_FILL;
          end
        end
        ST_FILL: begin
          if (mem.mem_ready) begin
            state_q <= ST_DONE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_q <= req_wr;
      tag_q <= req_addr[ADDR_BITS-1 -: TAG_BITS];
      idx_q <= req_addr[OFFSET_BITS +: INDEX_BITS];
      wsel_q <= req_addr[2 +: WSEL_BITS];
      wdata_q <= req_wdata;
    end
    if (state_q == ST_LOOKUP && tag_match) begin
      rdata_q <= pick_word(ls.hit_line, wsel_q);
    end else if (state_q == ST_FILL && mem.mem_ready) begin
      rdata_q <= pick_word(fill_merged, wsel_q);
    end
  end

  assign resp_rdata = rdata_q;
  assign resp_done = state_q == ST_DONE;
  assign resp_hit = hit_q;
  assign busy = state_q != ST_IDLE;

endmodule

`default_nettype wire

// File: logic/cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top #(
  parameter int ADDR_BITS = 16,
  parameter int INDEX_BITS = 6,
  parameter int DRAM_LATENCY = 4
) (
  input logic clk,
  input logic rst,
  input logic req_rd,
  input logic req_wr,
  input logic [ADDR_BITS-1:0] req_addr,
  input cache_pkg::word_t req_wdata,
  output cache_pkg::word_t resp_rdata,
  output logic resp_done,
  output logic resp_hit,
  output logic busy
);
  import cache_pkg::*;

  mem_bus_if #(
    .LINE_ADDR_BITS(ADDR_BITS - OFFSET_BITS)
  ) mem_bus ();

  line_store_if #(
    .ADDR_BITS(ADDR_BITS),
    .INDEX_BITS(INDEX_BITS)
  ) line_store ();

  cache_ctrl #(
    .ADDR_BITS(ADDR_BITS),
    .INDEX_BITS(INDEX_BITS)
  ) u_ctrl (
    .clk(clk),
    .rst(rst),
    .req_rd(req_rd),
    .req_wr(req_wr),
    .req_addr(req_addr),
    .req_wdata(req_wdata),
    .resp_rdata(resp_rdata),
    .resp_done(resp_done),
    .resp_hit(resp_hit),
    .busy(busy),
    .ls(line_store.ctrl),
    .mem(mem_bus.ctrl)
  );

  cache_array #(
    .ADDR_BITS(ADDR_BITS),
    .INDEX_BITS(INDEX_BITS)
  ) u_array (
    .clk(clk),
    .rst(rst),
    .ls(line_store.array)
  );

  // slow backing store
  dram_model #(
    .ADDR_BITS(ADDR_BITS),
    .DRAM_LATENCY(DRAM_LATENCY)
  ) u_dram (
    .clk(clk),
    .mem(mem_bus.memory)
  );

endmodule

`default_nettype wire

// File: dv/cache_sva.sv
`timescale 1ns/1ns
`default_nettype none

module cache_sva #(
  parameter int LINE_ADDR_BITS = 12
) (
  input logic clk,
  input logic rst,
  input logic wren,
  input logic rden,
  input logic [LINE_ADDR_BITS-1:0] line_addr,
  input cache_pkg::line_t wdata,
  input logic mem_ready,
  input logic resp_done,
  input logic busy,
  input cache_pkg::cache_state_e state
);
  import cache_pkg::*;

  // DRAM request held with address and data until ready
  a_wr_hold: assert property (@(posedge clk) disable iff (rst)
    wren && !mem_ready |=> wren && $stable(line_addr) && $stable(wdata))
    else $error("write request dropped or changed before mem_ready");

  a_rd_hold: assert property (@(posedge clk) disable iff (rst)
    rden && !mem_ready |=> rden && $stable(line_addr))
    else $error("read request dropped or changed before mem_ready");

  // request lowered the cycle after ready
  a_wr_release: assert property (@(posedge clk) disable iff (rst)
    wren && mem_ready |=> !wren)
    else $error("write request still high after mem_ready");

  a_rd_release: assert property (@(posedge clk) disable iff (rst)
    rden && mem_ready |=> !rden)
    else $error("read request still high after mem_ready");

  a_one_req: assert property (@(posedge clk) disable iff (rst)
    !(wren && rden))
    else $error("wren and rden high together");

  a_done_busy: assert property (@(posedge clk) disable iff (rst)
    resp_done |-> busy)
    else $error("resp_done while not busy");

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    resp_done |=> !resp_done)
    else $error("resp_done longer than one cycle");

  a_state_legal: assert property (@(posedge clk) disable iff (rst)
    state inside {ST_IDLE, ST_LOOKUP, ST_EVICT, ST_FILL, ST_DONE})
    else $error("controller state outside the FSM encoding");

endmodule

bind cache_ctrl cache_sva #(
  .LINE_ADDR_BITS(ADDR_BITS - cache_pkg::OFFSET_BITS)
) u_sva (
  .clk(clk),
  .rst(rst),
  .wren(mem.wren),
  .rden(mem.rden),
  .line_addr(mem.line_addr),
  .wdata(mem.wdata),
  .mem_ready(mem.mem_ready),
  .resp_done(resp_done),
  .busy(busy),
  .state(state_q)
);

`default_nettype wire

// File: dv/cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_tb;
  import cache_pkg::*;

  localparam int ADDR_BITS = 16;
  localparam int INDEX_BITS = 6;
  localparam int DRAM_LATENCY = 4;
  localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
  localparam int LINES = 2 ** INDEX_BITS;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_DIRECTED = 10;
  localparam int NUM_RANDOM = 300;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + (NUM_DIRECTED + NUM_RANDOM) * 200;

  typedef struct packed {
    logic rd;
    logic [ADDR_BITS-1:0] addr;
    word_t data;
    logic hit;
  } expect_t;

  logic clk;
  logic rst;
  logic req_rd;
  logic req_wr;
  logic [ADDR_BITS-1:0] req_addr;
  word_t req_wdata;
  word_t resp_rdata;
  logic resp_done;
  logic resp_hit;
  logic busy;

  // reference state
  word_t written [logic [ADDR_BITS-1:0]];
  logic model_valid [LINES];
  logic model_dirty [LINES];
  logic [TAG_BITS-1:0] model_tag [LINES];
  expect_t expect_q [$];
  integer seed = 8;
  int n_hits;
  int n_misses;
  int n_evicts;

  cache_top #(
    .ADDR_BITS(ADDR_BITS),
    .INDEX_BITS(INDEX_BITS),
    .DRAM_LATENCY(DRAM_LATENCY)
  ) u_dut (
    .clk(clk),
    .rst(rst),
    .req_rd(req_rd),
    .req_wr(req_wr),
    .req_addr(req_addr),
    .req_wdata(req_wdata),
    .resp_rdata(resp_rdata),
    .resp_done(resp_done),
    .resp_hit(resp_hit),
    .busy(busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input logic [ADDR_BITS-1:0] addr, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[FAIL] resp_rdata addr 0x%04h got 0x%08h expected 0x%08h", addr, got, exp);
      abort_run();
    end
  endtask

  task automatic check_hit(input logic [ADDR_BITS-1:0] addr, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] resp_hit addr 0x%04h got 0x%0h expected 0x%0h", addr, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] resp_done latency got 0x%0h expected 0x%0h cycles", got, exp);
      abort_run();
    end
  endtask

  // last written word, else the byte-index pattern of DRAM
  function automatic word_t expected_word(input logic [ADDR_BITS-1:0] addr);
    word_t w;
    if (written.exists(addr)) begin
      return written[addr];
    end
    for (int j = 0; j < $bits(word_t) / 8; j++) begin
      w[8*j +: 8] = 8'(addr + ADDR_BITS'(j));
    end
    return w;
  endfunction

  function automatic logic predict_hit(input logic [ADDR_BITS-1:0] addr);
    logic [INDEX_BITS-1:0] idx;
    idx = addr[OFFSET_BITS +: INDEX_BITS];
    return model_valid[idx] && (model_tag[idx] == addr[ADDR_BITS-1 -: TAG_BITS]);
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // one request, waits for resp_done, leaves the DUT idle
  task automatic access(input logic is_wr, input logic [ADDR_BITS-1:0] addr,
                        input word_t wdata, input logic exp_hit);
    expect_t e;
    int cycles;
    logic [INDEX_BITS-1:0] idx;
    logic hit;
    idx = addr[OFFSET_BITS +: INDEX_BITS];
    hit = predict_hit(addr);
    e.rd = !is_wr;
    e.addr = addr;
    e.data = expected_word(addr);
    e.hit = exp_hit;
    expect_q.push_back(e);
    if (hit) begin
      n_hits++;
      model_dirty[idx] = model_dirty[idx] || is_wr;
    end else begin
      n_misses++;
      if (model_valid[idx] && model_dirty[idx]) begin
        n_evicts++;
      end
      model_dirty[idx] = is_wr;
    end
    model_valid[idx] = 1'b1;
    model_tag[idx] = addr[ADDR_BITS-1 -: TAG_BITS];
    if (is_wr) begin
      written[addr] = wdata;
    end
    req_rd = !is_wr;
    req_wr = is_wr;
    req_addr = addr;
    req_wdata = wdata;
    @(posedge clk);
    #1;
    req_rd = 1'b0;
    req_wr = 1'b0;
    check_flag("busy", busy, 1'b1);
    cycles = 1;
    while (!resp_done) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (exp_hit) begin
      check_latency(cycles, 2);
    end
    @(posedge clk);
    #1;
    check_flag("busy", busy, 1'b0);
  endtask

  // compare at the falling edge, outputs settled
  initial begin : compare_responses
    expect_t e;
    forever begin
      @(negedge clk);
      if (resp_done === 1'b1) begin
        if (expect_q.size() == 0) begin
          $display("resp_done pulsed with no request outstanding");
          abort_run();
        end else begin
          e = expect_q.pop_front();
          check_hit(e.addr, resp_hit, e.hit);
          if (e.rd) begin
            check_word(e.addr, resp_rdata, e.data);
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the cache stopped responding within %0d cycles", TIMEOUT_CYCLES);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    logic is_wr;
    logic [ADDR_BITS-1:0] addr;
    rst = 1'b1;
    req_rd = 1'b0;
    req_wr = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    for (int i = 0; i < LINES; i++) begin
      model_valid[i] = 1'b0;
      model_dirty[i] = 1'b0;
      model_tag[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    check_flag("busy", busy, 1'b0);
    check_flag("resp_done", resp_done, 1'b0);
    check_flag("resp_hit", resp_hit, 1'b0);

    // first touch misses, then same line hits
    access(1'b0, 16'h0040, '0, 1'b0);
    access(1'b0, 16'h0044, '0, 1'b1);

    // write hit, read it back, neighbours keep the pattern
    access(1'b1, 16'h0048, 32'hdead_beef, 1'b1);
    access(1'b0, 16'h0048, '0, 1'b1);
    access(1'b0, 16'h004c, '0, 1'b1);
    access(1'b0, 16'h0040, '0, 1'b1);

    // same index, other tag, forces write-back of the dirty line
    access(1'b1, 16'h0080, 32'h1234_5678, 1'b0);
    access(1'b0, 16'h0480, '0, 1'b0);
    access(1'b0, 16'h0080, '0, 1'b0);
    access(1'b0, 16'h0084, '0, 1'b1);

    n_hits = 0;
    n_misses = 0;
    n_evicts = 0;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      is_wr = rand_below(2) == 1;
      addr = {TAG_BITS'(rand_below(4)), INDEX_BITS'(rand_below(4)), 2'(rand_below(4)), 2'b00};
      access(is_wr, addr, word_t'($random(seed)), predict_hit(addr));
    end
    $display("random mix: %0d hits, %0d misses, %0d dirty evictions",
             n_hits, n_misses, n_evicts);
    if (n_hits == 0 || n_evicts == 0 || n_misses <= n_evicts) begin
      $display("random mix missed hits, clean misses or dirty evictions");
      abort_run();
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
logic/cache_pkg.sv
logic/mem_bus_if.sv
logic/line_store_if.sv
logic/dram_model.sv
logic/cache_array.sv
logic/cache_ctrl.sv
logic/cache_top.sv
dv/cache_sva.sv
dv/cache_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module cache_tb \
  -Mdir obj_dir -o cache_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/cache_tb_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
